//--- include/dcache_settings.svh
`ifndef DCACHE_SETTINGS_SVH
`define DCACHE_SETTINGS_SVH

// Cache geometry
`define DC_ADDR_W   32
`define DC_WAYS     4
`define DC_SETS     16
`define DC_WORDS    16

// Address split, tag | index | word offset | byte
`define DC_INDEX_W  4
`define DC_OFFSET_W 4
`define DC_TAG_W    (`DC_ADDR_W - `DC_INDEX_W - `DC_OFFSET_W - 2)

`endif

//--- logic/dcache_pkg.sv
`default_nettype none

package dcache_pkg;

  `include "dcache_settings.svh"

  typedef logic [31:0]               word_t;
  typedef logic [`DC_TAG_W-1:0]      tag_t;
  typedef logic [`DC_INDEX_W-1:0]    index_t;
  typedef logic [`DC_OFFSET_W-1:0]   offset_t;
  typedef logic [1:0]                way_t;
  typedef logic [1:0]                age_t;   // 0 is most recent
  typedef word_t [`DC_WORDS-1:0]     line_t;
  typedef logic [3:0]                byte_en_t;

  typedef enum logic [2:0] {IDLE, LOOKUP, EVICT, FILL, UPDATE} ctrl_state_e;

  typedef enum logic [1:0] {ENG_IDLE, ENG_REQ, ENG_DONE} eng_state_e;

endpackage

`default_nettype wire

//--- logic/mem_bus_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcache_settings.svh"

// Wishbone classic, one beat per cyc/stb pair
interface mem_bus_if;

  logic                   cyc;
  logic                   stb;
  logic                   we;
  logic [`DC_ADDR_W-1:0]  adr;
  dcache_pkg::byte_en_t   sel;
  dcache_pkg::word_t      wdata;
  dcache_pkg::word_t      rdata;
  logic                   ack;

  modport master (output cyc, stb, we, adr, sel, wdata, input rdata, ack);
  modport slave  (input cyc, stb, we, adr, sel, wdata, output rdata, ack);

endinterface

`default_nettype wire

//--- logic/dcache_store.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcache_settings.svh"

module dcache_store (
  input  logic                  clk,
  input  logic                  rst,
  input  dcache_pkg::index_t    index,
  input  dcache_pkg::tag_t      lookup_tag,
  output logic                  hit,
  output dcache_pkg::way_t      hit_way,
  output dcache_pkg::way_t      victim_way,
  output logic                  victim_dirty,
  output dcache_pkg::tag_t      victim_tag,
  output dcache_pkg::line_t     line_rdata,
  input  logic                  wr_word,
  input  dcache_pkg::offset_t   wr_offset,
  input  dcache_pkg::word_t     wr_data,
  input  dcache_pkg::byte_en_t  wr_sel,
  input  logic                  fill,
  input  dcache_pkg::line_t     fill_line,
  input  logic                  touch,
  input  dcache_pkg::way_t      way
);

  dcache_pkg::tag_t   tag_mem   [`DC_WAYS][`DC_SETS];
  dcache_pkg::line_t  data_mem  [`DC_WAYS][`DC_SETS];
  logic               valid_mem [`DC_WAYS][`DC_SETS];
  logic               dirty_mem [`DC_WAYS][`DC_SETS];
  dcache_pkg::age_t   age_mem   [`DC_WAYS][`DC_SETS];

  ////////////////////////////////////////////////////////////
  // Lookup and victim choice

  always_comb
  begin : hit_detect
    hit     = 1'b0;
    hit_way = '0;
    for (int w = 0; w < `DC_WAYS; w++)
      if (valid_mem[w][index] && tag_mem[w][index] == lookup_tag)
      begin
        hit     = 1'b1;
        hit_way = dcache_pkg::way_t'(w);
      end
  end

  always_comb
  begin : victim_pick
    logic found;
    found      = 1'b0;
    victim_way = '0;
    for (int w = 0; w < `DC_WAYS; w++)
      if (!found && !valid_mem[w][index])
      begin
        found      = 1'b1;
        victim_way = dcache_pkg::way_t'(w);
      end
    // All valid, take the oldest, lowest way on a tie
    if (!found)
      for (int w = 1; w < `DC_WAYS; w++)
        if (age_mem[w][index] > age_mem[victim_way][index])
          victim_way = dcache_pkg::way_t'(w);
  end

  assign victim_dirty = dirty_mem[victim_way][index];
  assign victim_tag   = tag_mem[victim_way][index];
  assign line_rdata   = data_mem[way][index];

  ////////////////////////////////////////////////////////////
  // Updates

  always_ff @(posedge clk)
  begin
    if (fill)
    begin
      tag_mem[way][index]  <= lookup_tag;
      data_mem[way][index] <= fill_line;
    end
    else if (wr_word)
      for (int b = 0; b < 4; b++)
        if (wr_sel[b])
          data_mem[way][index][wr_offset][8*b +: 8] <= wr_data[8*b +: 8];
  end

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      valid_mem <= '{default: '0};
      dirty_mem <= '{default: '0};
      age_mem   <= '{default: '0};
    end
    else
    begin
      if (fill)
      begin
        valid_mem[way][index] <= 1'b1;
        dirty_mem[way][index] <= 1'b0;
      end
      else if (wr_word)
        dirty_mem[way][index] <= 1'b1;

      if (touch)
        for (int w = 0; w < `DC_WAYS; w++)
          if (dcache_pkg::way_t'(w) == way)
            age_mem[w][index] <= '0;
          else if (age_mem[w][index] <= age_mem[way][index] && age_mem[w][index] != '1)
            age_mem[w][index] <= age_mem[w][index] + 1'b1;   // Saturates at 3
    end
  end

  // Refill and word writes come from different controller states
  fill_vs_write: assert property (@(posedge clk) disable iff (rst) !(fill && wr_word));

endmodule

`default_nettype wire

//--- logic/dcache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcache_settings.svh"

module dcache_ctrl (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   req,
  input  logic                   we,
  input  logic [`DC_ADDR_W-1:0]  addr,
  input  dcache_pkg::word_t      wdata,
  input  dcache_pkg::byte_en_t   wbyte,
  output dcache_pkg::word_t      rdata,
  output logic                   ok,
  output dcache_pkg::index_t     index,
  output dcache_pkg::tag_t       lookup_tag,
  output logic                   wr_word,
  output dcache_pkg::offset_t    wr_offset,
  output dcache_pkg::word_t      wr_data,
  output dcache_pkg::byte_en_t   wr_sel,
  output logic                   fill,
  output logic                   touch,
  output dcache_pkg::way_t       way,
  input  logic                   hit,
  input  dcache_pkg::way_t       hit_way,
  input  dcache_pkg::way_t       victim_way,
  input  logic                   victim_dirty,
  input  dcache_pkg::line_t      line_rdata,
  output logic                   refill_start,
  output logic [`DC_ADDR_W-1:0]  refill_addr,
  input  logic                   refill_done,
  input  dcache_pkg::line_t      refill_line,
  output logic                   wb_start,
  input  logic                   wb_done
);

  localparam int LINE_LSB = `DC_OFFSET_W + 2;

  dcache_pkg::ctrl_state_e state;

  logic [`DC_ADDR_W-1:0]  addr_q;
  logic                   we_q;
  dcache_pkg::word_t      wdata_q;
  dcache_pkg::byte_en_t   wbyte_q;
  dcache_pkg::way_t       victim_q;
  logic                   dirty_q;
  logic                   rf_fin;
  logic                   wb_fin;
  logic                   both_done;

  assign lookup_tag = addr_q[`DC_ADDR_W-1 -: `DC_TAG_W];
  assign index      = addr_q[LINE_LSB +: `DC_INDEX_W];
  assign wr_offset  = addr_q[2 +: `DC_OFFSET_W];
  assign wr_data    = wdata_q;
  assign wr_sel     = wbyte_q;

  assign refill_addr  = {addr_q[`DC_ADDR_W-1:LINE_LSB], {LINE_LSB{1'b0}}};
  assign refill_start = (state == dcache_pkg::EVICT);
  assign wb_start     = (state == dcache_pkg::EVICT) && dirty_q;   // Clean victim is dropped

  // An engine that was not started is marked finished in EVICT
  assign both_done = (rf_fin || refill_done) && (wb_fin || wb_done);

  // Store strobes
  assign way     = (state == dcache_pkg::LOOKUP) ? hit_way : victim_q;
  assign fill    = (state == dcache_pkg::FILL) && both_done;
  assign wr_word = we_q && ((state == dcache_pkg::LOOKUP && hit) ||
                            state == dcache_pkg::UPDATE);
  assign touch   = (state == dcache_pkg::LOOKUP && hit) || state == dcache_pkg::UPDATE;

  ////////////////////////////////////////////////////////////
  // Request FSM

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      state    <= dcache_pkg::IDLE;
      ok       <= 1'b0;
      victim_q <= '0;
      dirty_q  <= 1'b0;
      rf_fin   <= 1'b0;
      wb_fin   <= 1'b0;
    end
    else
    begin
      ok <= 1'b0;
      case (state)
        dcache_pkg::IDLE:
          if (req)
            state <= dcache_pkg::LOOKUP;
        dcache_pkg::LOOKUP:
          if (hit)
          begin
            ok    <= 1'b1;
            state <= dcache_pkg::IDLE;
          end
          else
          begin
            victim_q <= victim_way;
            dirty_q  <= victim_dirty;
            state    <= dcache_pkg::EVICT;
          end
        dcache_pkg::EVICT:
        begin
          rf_fin <= 1'b0;
          wb_fin <= !dirty_q;
          state  <= dcache_pkg::FILL;
        end
        dcache_pkg::FILL:
        begin
          if (refill_done)
            rf_fin <= 1'b1;
          if (wb_done)
            wb_fin <= 1'b1;
          if (both_done)
            state <= dcache_pkg::UPDATE;   // Line written on this edge
        end
        dcache_pkg::UPDATE:
        begin
          ok    <= 1'b1;
          state <= dcache_pkg::IDLE;
        end
        default:
          state <= dcache_pkg::IDLE;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (state == dcache_pkg::IDLE && req)
    begin
      addr_q  <= addr;
      we_q    <= we;
      wdata_q <= wdata;
      wbyte_q <= wbyte;
    end
    if (state == dcache_pkg::LOOKUP && hit)
      rdata <= line_rdata[wr_offset];
    else if (state == dcache_pkg::UPDATE)
      rdata <= refill_line[wr_offset];
  end

  // Engines finish only while the FSM waits in FILL
  done_in_fill: assert property (@(posedge clk) disable iff (rst)
    (refill_done || wb_done) |-> state == dcache_pkg::FILL);

endmodule

`default_nettype wire

//--- logic/line_refill.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcache_settings.svh"

module line_refill (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   start,
  input  logic [`DC_ADDR_W-1:0]  line_addr,
  output logic                   done,
  output dcache_pkg::line_t      line,
  mem_bus_if.master              bus
);

  localparam int LINE_LSB = `DC_OFFSET_W + 2;

  dcache_pkg::eng_state_e             state;
  dcache_pkg::offset_t                beat;
  logic [`DC_ADDR_W-1:LINE_LSB]       base;
  logic                               cyc_q;

  assign bus.cyc   = cyc_q;
  assign bus.stb   = cyc_q;
  assign bus.we    = 1'b0;
  assign bus.sel   = '1;
  assign bus.wdata = '0;
  assign bus.adr   = {base, beat, 2'b00};
  assign done      = (state == dcache_pkg::ENG_DONE);

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      state <= dcache_pkg::ENG_IDLE;
      cyc_q <= 1'b0;
      beat  <= '0;
    end
    else
      case (state)
        dcache_pkg::ENG_IDLE:
          if (start)
          begin
            cyc_q <= 1'b1;
            beat  <= '0;
            state <= dcache_pkg::ENG_REQ;
          end
        dcache_pkg::ENG_REQ:
          if (!cyc_q)
            cyc_q <= 1'b1;   // Next beat after the idle cycle
          else if (bus.ack)
          begin
            cyc_q <= 1'b0;
            beat  <= beat + 1'b1;
            if (beat == '1)
              state <= dcache_pkg::ENG_DONE;
          end
        default:
          state <= dcache_pkg::ENG_IDLE;
      endcase
  end

  always_ff @(posedge clk)
  begin
    if (state == dcache_pkg::ENG_IDLE && start)
      base <= line_addr[`DC_ADDR_W-1:LINE_LSB];
    if (cyc_q && bus.ack)
      line[beat] <= bus.rdata;
  end

endmodule

`default_nettype wire

//--- logic/line_writeback.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcache_settings.svh"

module line_writeback (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   start,
  input  dcache_pkg::line_t      victim_line,
  input  logic [`DC_ADDR_W-1:0]  victim_addr,
  output logic                   done,
  mem_bus_if.master              bus
);

  localparam int LINE_LSB = `DC_OFFSET_W + 2;

  dcache_pkg::eng_state_e         state;
  dcache_pkg::offset_t            beat;
  dcache_pkg::line_t              line_q;   // Store may be refilled meanwhile
  logic [`DC_ADDR_W-1:LINE_LSB]   base;
  logic                           cyc_q;

  assign bus.cyc   = cyc_q;
  assign bus.stb   = cyc_q;
  assign bus.we    = 1'b1;
  assign bus.sel   = '1;
  assign bus.wdata = line_q[beat];
  assign bus.adr   = {base, beat, 2'b00};
  assign done      = (state == dcache_pkg::ENG_DONE);

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      state <= dcache_pkg::ENG_IDLE;
      cyc_q <= 1'b0;
      beat  <= '0;
    end
    else
      case (state)
        dcache_pkg::ENG_IDLE:
          if (start)
          begin
            cyc_q <= 1'b1;
            beat  <= '0;
            state <= dcache_pkg::ENG_REQ;
          end
        dcache_pkg::ENG_REQ:
          if (!cyc_q)
            cyc_q <= 1'b1;
          else if (bus.ack)
          begin
            cyc_q <= 1'b0;
            beat  <= beat + 1'b1;
            if (beat == '1)
              state <= dcache_pkg::ENG_DONE;
          end
        default:
          state <= dcache_pkg::ENG_IDLE;
      endcase
  end

  always_ff @(posedge clk)
    if (state == dcache_pkg::ENG_IDLE && start)
    begin
      line_q <= victim_line;
      base   <= victim_addr[`DC_ADDR_W-1:LINE_LSB];
    end

endmodule

`default_nettype wire

//--- logic/mem_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcache_settings.svh"

module mem_arbiter (
  input  logic                   clk,
  input  logic                   rst,
  mem_bus_if.slave               wb_side,
  mem_bus_if.slave               rf_side,
  output logic                   mem_cyc,
  output logic                   mem_stb,
  output logic                   mem_we,
  output logic [`DC_ADDR_W-1:0]  mem_adr,
  output dcache_pkg::byte_en_t   mem_sel,
  output dcache_pkg::word_t      mem_wdata,
  input  dcache_pkg::word_t      mem_rdata,
  input  logic                   mem_ack
);

  logic busy;      // A beat is granted
  logic gnt_rf;    // Owner of the grant, 1 for refill
  logic prio_rf;   // Refill wins the next tie

  assign mem_cyc   = busy && (gnt_rf ? rf_side.cyc : wb_side.cyc);
  assign mem_stb   = busy && (gnt_rf ? rf_side.stb : wb_side.stb);
  assign mem_we    = gnt_rf ? rf_side.we    : wb_side.we;
  assign mem_adr   = gnt_rf ? rf_side.adr   : wb_side.adr;
  assign mem_sel   = gnt_rf ? rf_side.sel   : wb_side.sel;
  assign mem_wdata = gnt_rf ? rf_side.wdata : wb_side.wdata;

  // Return path only to the owner
  assign rf_side.ack   = busy && gnt_rf && mem_ack;
  assign wb_side.ack   = busy && !gnt_rf && mem_ack;
  assign rf_side.rdata = (busy && gnt_rf) ? mem_rdata : '0;
  assign wb_side.rdata = (busy && !gnt_rf) ? mem_rdata : '0;

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      busy    <= 1'b0;
      gnt_rf  <= 1'b0;
      prio_rf <= 1'b0;   // Write-back first
    end
    else if (!busy)
    begin
      if (wb_side.cyc && (!rf_side.cyc || !prio_rf))
      begin
        busy   <= 1'b1;
        gnt_rf <= 1'b0;
      end
      else if (rf_side.cyc)
      begin
        busy   <= 1'b1;
        gnt_rf <= 1'b1;
      end
    end
    else if (mem_ack)
    begin
      busy    <= 1'b0;
      prio_rf <= !gnt_rf;
    end
  end

  stb_needs_cyc: assert property (@(posedge clk) disable iff (rst) mem_stb |-> mem_cyc);

endmodule

`default_nettype wire

//--- logic/dcache_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcache_settings.svh"

module dcache_top (
  input  logic                   clk,
  input  logic                   rst,
  // CPU side
  input  logic                   req,
  input  logic                   we,
  input  logic [`DC_ADDR_W-1:0]  addr,
  input  dcache_pkg::word_t      wdata,
  input  dcache_pkg::byte_en_t   wbyte,
  output dcache_pkg::word_t      rdata,
  output logic                   ok,
  // Memory side
  output logic                   mem_cyc,
  output logic                   mem_stb,
  output logic                   mem_we,
  output logic [`DC_ADDR_W-1:0]  mem_adr,
  output dcache_pkg::byte_en_t   mem_sel,
  output dcache_pkg::word_t      mem_wdata,
  input  dcache_pkg::word_t      mem_rdata,
  input  logic                   mem_ack
);

  dcache_pkg::index_t     index;
  dcache_pkg::tag_t       lookup_tag;
  logic                   hit;
  dcache_pkg::way_t       hit_way;
  dcache_pkg::way_t       victim_way;
  logic                   victim_dirty;
  dcache_pkg::tag_t       victim_tag;
  dcache_pkg::line_t      line_rdata;
  logic                   wr_word;
  dcache_pkg::offset_t    wr_offset;
  dcache_pkg::word_t      wr_data;
  dcache_pkg::byte_en_t   wr_sel;
  logic                   fill;
  logic                   touch;
  dcache_pkg::way_t       way;
  logic                   refill_start;
  logic [`DC_ADDR_W-1:0]  refill_addr;
  logic                   refill_done;
  dcache_pkg::line_t      refill_line;
  logic                   wb_start;
  logic                   wb_done;
  logic [`DC_ADDR_W-1:0]  victim_addr;

  mem_bus_if rf_bus ();
  mem_bus_if wb_bus ();

  assign victim_addr = {victim_tag, index, {(`DC_OFFSET_W + 2){1'b0}}};

  dcache_ctrl ctrl_i (
    .clk, .rst, .req, .we, .addr, .wdata, .wbyte, .rdata, .ok,
    .index, .lookup_tag, .wr_word, .wr_offset, .wr_data, .wr_sel, .fill, .touch, .way,
    .hit, .hit_way, .victim_way, .victim_dirty, .line_rdata,
    .refill_start, .refill_addr, .refill_done, .refill_line,
    .wb_start, .wb_done
  );

  dcache_store store_i (
    .clk, .rst, .index, .lookup_tag, .hit, .hit_way,
    .victim_way, .victim_dirty, .victim_tag, .line_rdata,
    .wr_word, .wr_offset, .wr_data, .wr_sel,
    .fill, .fill_line(refill_line), .touch, .way
  );

  line_refill refill_i (
    .clk, .rst,
    .start     (refill_start),
    .line_addr (refill_addr),
    .done      (refill_done),
    .line      (refill_line),
    .bus       (rf_bus)
  );

  line_writeback writeback_i (
    .clk, .rst,
    .start       (wb_start),
    .victim_line (line_rdata),
    .victim_addr (victim_addr),
    .done        (wb_done),
    .bus         (wb_bus)
  );

  mem_arbiter arbiter_i (
    .clk, .rst,
    .wb_side (wb_bus),
    .rf_side (rf_bus),
    .mem_cyc, .mem_stb, .mem_we, .mem_adr, .mem_sel, .mem_wdata, .mem_rdata, .mem_ack
  );

endmodule

`default_nettype wire

//--- bench/dcache_checker.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_checker (
  input  logic         clk,
  input  logic         rst,
  input  logic         req,
  input  logic         we,
  input  logic [31:0]  addr,
  input  logic [31:0]  wdata,
  input  logic [3:0]   wbyte,
  input  logic [31:0]  rdata,
  input  logic         ok,
  input  logic         mem_cyc,
  input  logic         mem_stb,
  input  logic         mem_we,
  input  logic [31:0]  mem_adr,
  input  logic [3:0]   mem_sel,
  input  logic [31:0]  mem_wdata,
  input  logic         mem_ack,
  output int           error_count,
  output int           rd_beats,
  output int           wr_beats,
  output logic [31:0]  last_wr_adr
);

  logic [31:0]  ref_mem [2048];   // Flat view of the 8 KB window
  logic         pending_q;
  logic [31:0]  adr_q;
  logic [31:0]  wdata_q;
  logic         we_q;
  logic [3:0]   sel_q;
  logic [3:0]   wr_offset;
  logic         cpu_we_q;
  logic [31:0]  cpu_addr_q;
  logic [31:0]  cpu_wdata_q;
  logic [3:0]   cpu_wbyte_q;

  function automatic logic [31:0] initial_word(int idx);
    return (idx * 32'h9e37_79b1) ^ {idx[15:0], ~idx[15:0]};
  endfunction

  initial
  begin
    for (int i = 0; i < 2048; i++)
      ref_mem[i] = initial_word(i);
    error_count = 0;
    rd_beats    = 0;
    wr_beats    = 0;
    last_wr_adr = '0;
    pending_q   = 1'b0;
    wr_offset   = '0;
    cpu_we_q    = 1'b0;
    cpu_addr_q  = '0;
    cpu_wdata_q = '0;
    cpu_wbyte_q = '0;
  end

  ////////////////////////////////////////////////////////////
  // CPU side against the flat model

  always @(posedge clk)
  begin : cpu_check
    int idx;
    idx = cpu_addr_q[12:2];
    if (!rst && ok)
    begin
      if (cpu_we_q)
      begin
        for (int b = 0; b < 4; b++)
          if (cpu_wbyte_q[b])
            ref_mem[idx][8*b +: 8] = cpu_wdata_q[8*b +: 8];
      end
      else if (rdata !== ref_mem[idx])
      begin
        error_count++;
        $display("error at %0t: rdata is %h, expected %h", $time, rdata, ref_mem[idx]);
      end
    end
    // ok is seen one edge late, after the CPU may have moved on
    if (req)
    begin
      cpu_we_q    = we;
      cpu_addr_q  = addr;
      cpu_wdata_q = wdata;
      cpu_wbyte_q = wbyte;
    end
  end

  ////////////////////////////////////////////////////////////
  // Wishbone rules and write-back contents

  always @(posedge clk)
  begin : bus_check
    if (!rst)
    begin
      if (mem_stb && !mem_cyc)
      begin
        error_count++;
        $display("bus rule broken at %0t: stb raised without cyc", $time);
      end
      if (pending_q && mem_stb && (mem_adr !== adr_q || mem_we !== we_q ||
                                   mem_sel !== sel_q || mem_wdata !== wdata_q))
      begin
        error_count++;
        $display("bus rule broken at %0t: adr, we, sel or wdata moved before ack", $time);
      end
      if (mem_cyc && mem_stb && mem_ack)
      begin
        if (mem_we)
        begin
          wr_beats++;
          last_wr_adr = mem_adr;
          if (mem_adr[5:2] !== wr_offset)
          begin
            error_count++;
            $display("error at %0t: mem_adr offset is %0d, expected %0d",
                     $time, mem_adr[5:2], wr_offset);
          end
          if (mem_sel !== 4'hf)
          begin
            error_count++;
            $display("error at %0t: mem_sel is %h, expected f", $time, mem_sel);
          end
          if (mem_wdata !== ref_mem[mem_adr[12:2]])
          begin
            error_count++;
            $display("error at %0t: mem_wdata is %h, expected %h",
                     $time, mem_wdata, ref_mem[mem_adr[12:2]]);
          end
          wr_offset++;   // Beats run 0 to 15 per line
        end
        else
          rd_beats++;
      end
      pending_q = mem_cyc && mem_stb && !mem_ack;
      adr_q     = mem_adr;
      we_q      = mem_we;
      sel_q     = mem_sel;
      wdata_q   = mem_wdata;
    end
  end

endmodule

`default_nettype wire

//--- bench/dcache_tb.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_tb;

  localparam int LIMIT = 500;   // Cycles per wait

  logic         clk;
  logic         rst;
  logic         req;
  logic         we;
  logic [31:0]  addr;
  logic [31:0]  wdata;
  logic [3:0]   wbyte;
  logic [31:0]  rdata;
  logic         ok;
  logic         mem_cyc;
  logic         mem_stb;
  logic         mem_we;
  logic [31:0]  mem_adr;
  logic [3:0]   mem_sel;
  logic [31:0]  mem_wdata;
  logic [31:0]  mem_rdata;
  logic         mem_ack;

  logic [31:0]  mem [2048];
  int           seed;
  int           ack_seed;
  int           wait_left;
  logic         pending;
  int           tb_errors;
  int           tests_run;
  int           tests_failed;
  int           err_mark;
  int           error_count;
  int           rd_beats;
  int           wr_beats;
  logic [31:0]  last_wr_adr;

  dcache_top dcache_top_i (
    .clk, .rst, .req, .we, .addr, .wdata, .wbyte, .rdata, .ok,
    .mem_cyc, .mem_stb, .mem_we, .mem_adr, .mem_sel, .mem_wdata, .mem_rdata, .mem_ack
  );

  dcache_checker checker_i (
    .clk, .rst, .req, .we, .addr, .wdata, .wbyte, .rdata, .ok,
    .mem_cyc, .mem_stb, .mem_we, .mem_adr, .mem_sel, .mem_wdata, .mem_ack,
    .error_count, .rd_beats, .wr_beats, .last_wr_adr
  );

  always #5 clk = ~clk;

  function automatic logic [31:0] initial_word(int idx);
    return (idx * 32'h9e37_79b1) ^ {idx[15:0], ~idx[15:0]};
  endfunction

  function automatic logic [31:0] make_addr(int tag, int set, int offset);
    return {19'd0, tag[2:0], set[3:0], offset[3:0], 2'b00};
  endfunction

  ////////////////////////////////////////////////////////////
  // Memory slave, ack after 0 to 3 idle cycles

  always @(negedge clk)
  begin
    if (rst)
    begin
      mem_ack = 1'b0;
      pending = 1'b0;
    end
    else if (mem_ack)
      mem_ack = 1'b0;
    else if (mem_cyc && mem_stb)
    begin
      if (!pending)
      begin
        pending   = 1'b1;
        wait_left = $random(ack_seed) & 3;
      end
      if (wait_left == 0)
      begin
        pending = 1'b0;
        mem_ack = 1'b1;
        if (mem_we)
        begin
          for (int b = 0; b < 4; b++)
            if (mem_sel[b])
              mem[mem_adr[12:2]][8*b +: 8] = mem_wdata[8*b +: 8];
        end
        else
          mem_rdata = mem[mem_adr[12:2]];
      end
      else
        wait_left--;
    end
  end

  ////////////////////////////////////////////////////////////
  // Helpers

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("test failed");
    $finish;
  endtask

  // One CPU access; cycles counts edges from req to the ok pulse
  task automatic access(input logic w, input logic [31:0] a, input logic [31:0] d,
                        input logic [3:0] be, output logic [31:0] q, output int cycles);
    req    = 1'b1;
    we     = w;
    addr   = a;
    wdata  = d;
    wbyte  = be;
    cycles = 0;
    do
    begin
      @(negedge clk);
      cycles++;
    end while (!ok && cycles < LIMIT);
    if (!ok)
      stop_run($sformatf("no ok from the cache within %0d cycles", LIMIT));
    else
    begin
      q   = rdata;
      req = 1'b0;
    end
  endtask

  // A hit must take 2 cycles and no bus beat
  task automatic expect_hit(input logic [31:0] a);
    int          beats;
    int          cycles;
    logic [31:0] q;
    beats = rd_beats + wr_beats;
    access(1'b0, a, '0, '0, q, cycles);
    if (cycles != 2)
    begin
      tb_errors++;
      $display("error at %0t: ok latency is %0d, expected 2", $time, cycles);
    end
    if (rd_beats + wr_beats != beats)
    begin
      tb_errors++;
      $display("address %h was expected to hit but went to memory", a);
    end
  endtask

  task automatic finish_test(input string name);
    @(negedge clk);   // Checker sees the last ok one edge late
    tests_run++;
    if (error_count + tb_errors != err_mark)
    begin
      tests_failed++;
      $display("%s: FAIL", name);
    end
    else
      $display("%s: ok", name);
    err_mark = error_count + tb_errors;
  endtask

  ////////////////////////////////////////////////////////////
  // Test sequence

  initial
  begin : run
    logic [31:0] q;
    logic [31:0] a;
    int          cycles;
    int          beats;
    clk = 1'b0;
    rst = 1'b1;
    req = 1'b0;
    we = 1'b0;
    addr = '0;
    wdata = '0;
    wbyte = '0;
    mem_rdata = '0;
    mem_ack = 1'b0;
    pending = 1'b0;
    wait_left = 0;
    seed = 41669;
    ack_seed = 41669;
    tb_errors = 0;
    tests_run = 0;
    tests_failed = 0;
    err_mark = 0;
    for (int i = 0; i < 2048; i++)
      mem[i] = initial_word(i);

    // Reset, outputs quiet during and after
    for (int i = 0; i < 8; i++)
    begin
      @(negedge clk);
      if (i == 5)
        rst = 1'b0;
      if (ok || mem_cyc || mem_stb)
      begin
        tb_errors++;
        $display("ok, mem_cyc or mem_stb high around reset at %0t", $time);
      end
    end
    finish_test("reset");

    // LRU in set 5, tag 1 is the oldest once tag 0 is re-touched
    for (int t = 0; t < 4; t++)
      access(1'b0, make_addr(t, 5, 0), '0, '0, q, cycles);
    access(1'b0, make_addr(0, 5, 1), '0, '0, q, cycles);
    access(1'b0, make_addr(4, 5, 0), '0, '0, q, cycles);
    expect_hit(make_addr(0, 5, 2));
    expect_hit(make_addr(2, 5, 3));
    expect_hit(make_addr(3, 5, 4));
    beats = rd_beats;
    access(1'b0, make_addr(1, 5, 0), '0, '0, q, cycles);
    if (rd_beats == beats)
    begin
      tb_errors++;
      $display("tag 1 in set 5 should have been evicted but still hit");
    end
    finish_test("lru");

    // Dirty victim in set 9 drains 16 beats, a clean one none
    access(1'b1, make_addr(0, 9, 3), $random(seed), 4'b1011, q, cycles);
    for (int t = 1; t < 4; t++)
      access(1'b0, make_addr(t, 9, 0), '0, '0, q, cycles);
    beats = wr_beats;
    access(1'b0, make_addr(4, 9, 0), '0, '0, q, cycles);
    if (wr_beats - beats != 16 || last_wr_adr[31:6] != make_addr(0, 9, 0) >> 6)
    begin
      tb_errors++;
      $display("dirty victim gave %0d write beats ending at %h", wr_beats - beats,
               last_wr_adr);
    end
    beats = wr_beats;
    access(1'b0, make_addr(5, 9, 0), '0, '0, q, cycles);
    if (wr_beats != beats)
    begin
      tb_errors++;
      $display("clean victim was written back");
    end
    finish_test("writeback");

    // Second access to a just-used line
    for (int i = 0; i < 20; i++)
    begin
      a = $random(seed) & 32'h1ffc;
      access(1'b0, a, '0, '0, q, cycles);
      expect_hit({a[31:6], 4'($random(seed)), 2'b00});
    end
    finish_test("repeat_hit");

    // Random mix, the checker compares every read
    for (int i = 0; i < 400; i++)
      access($random(seed) & 1, $random(seed) & 32'h1ffc, $random(seed),
             $random(seed) & 4'hf, q, cycles);
    finish_test("random_mix");

    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed,
             error_count + tb_errors);
    if (tests_failed == 0)
      $display("test passed");
    else
      $display("test failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+include
logic/dcache_pkg.sv
logic/mem_bus_if.sv
logic/dcache_store.sv
logic/dcache_ctrl.sv
logic/line_refill.sv
logic/line_writeback.sv
logic/mem_arbiter.sv
logic/dcache_top.sv
bench/dcache_checker.sv
bench/dcache_tb.sv

//--- Bender.yml
package:
  name: dcache

sources:
  - include_dirs:
      - include
    files:
      - logic/dcache_pkg.sv
      - logic/mem_bus_if.sv
      - logic/dcache_store.sv
      - logic/dcache_ctrl.sv
      - logic/line_refill.sv
      - logic/line_writeback.sv
      - logic/mem_arbiter.sv
      - logic/dcache_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - bench/dcache_checker.sv
      - bench/dcache_tb.sv
